// ==== build.f ====
+incdir+rtl
rtl/mtrap_pkg.sv
rtl/csr_access_if.sv
rtl/csr_axil_slave.sv
rtl/csr_regs.sv
rtl/irq_arbiter.sv
rtl/trap_ctrl.sv
rtl/mtrap_unit.sv
tests/mtrap_unit_properties.sv
tests/mtrap_unit_tb.sv

// ==== Makefile ====
# Verilator lint, simulation and clean targets for the machine trap unit.
VERILATOR ?= verilator
TOP       ?= mtrap_unit_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= PASS: all tests

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/mtrap_unit_tb.sv ====
// Testbench for the machine trap unit: clock, reset, AXI tasks, stimulus and report.
`timescale 1ns/1ps
`include "mtrap_consts.svh"

module mtrap_unit_tb import mtrap_pkg::*; ();
    localparam logic [`XLEN-1:0] hart_id_value = 32'h0000_0003;
    // Cycles of reset, bus traffic and events in all tests.
    localparam int test_cycles = 101;
    localparam int cycle_limit = 2 * test_cycles;

    logic                           clk = 1'b0;
    logic                           rst;
    logic [`IRQ_EXT_HI:`IRQ_EXT_LO] irq;
    logic                           timer_irq;
    logic                           retire_valid;
    logic [`XLEN-1:1]               retire_pc;
    logic                           trap_valid;
    trap_cause_t                    trap_cause;
    logic                           xret;
    logic                           redirect;
    logic [`XLEN-1:1]               redirect_pc;
    priv_t                          priv;
    logic                           awvalid;
    logic                           awready;
    logic [11:0]                    awaddr;
    logic                           wvalid;
    logic                           wready;
    logic [`XLEN-1:0]               wdata;
    logic                           bvalid;
    logic                           bready;
    logic [1:0]                     bresp;
    logic                           arvalid;
    logic                           arready;
    logic [11:0]                    araddr;
    logic                           rvalid;
    logic                           rready;
    logic [`XLEN-1:0]               rdata;
    logic [1:0]                     rresp;
    int                             errors = 0;
    int                             cycles = 0;
    logic [31:0]                    lcg_state = 32'd6;

    always #50 clk = ~clk;

    mtrap_unit #(.hart_id(hart_id_value)) UUT (.*);

    bind mtrap_unit mtrap_unit_properties props (.*);

    // Run limit.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error: time %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Master side of one write; hold keeps bready low for that many cycles.
    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        @(negedge clk);
        while (!awready) begin
            @(negedge clk);
        end
        // Commit happened on the edge just passed.
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) begin
            @(negedge clk);
        end
        repeat (hold) @(negedge clk);
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) begin
            @(negedge clk);
        end
        repeat (hold) @(negedge clk);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [31:0] expected,
                               input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, 0, data, resp);
        compare_value({name, " rresp"}, {30'b0, `RESP_OKAY}, {30'b0, resp});
        compare_value({name, " rdata"}, expected, data);
    endtask

    initial begin
        logic [31:0] val;
        logic [31:0] data;
        logic [1:0]  resp;
        csr_word_u   word;
        rst          = 1'b1;
        irq          = '0;
        timer_irq    = 1'b0;
        retire_valid = 1'b0;
        retire_pc    = '0;
        trap_valid   = 1'b0;
        trap_cause   = '0;
        xret         = 1'b0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Plain register access.
        val = next_rand();
        axi_write(`CSR_MSCRATCH, val, 0, resp);
        read_expect(`CSR_MSCRATCH, val, "mscratch");
        val = next_rand();
        axi_write(`CSR_MTVEC, val, 0, resp);
        read_expect(`CSR_MTVEC, val & ~32'h3, "mtvec");
        val = next_rand();
        axi_write(`CSR_MEPC, val, 0, resp);
        read_expect(`CSR_MEPC, val & ~32'h1, "mepc");
        read_expect(`CSR_MARCHID, 32'd37, "marchid");
        read_expect(`CSR_MHARTID, hart_id_value, "mhartid");

        // Access errors, with a master slow to take the responses.
        axi_write(`CSR_MHARTID, next_rand(), 4, resp);
        compare_value("bresp", {30'b0, `RESP_SLVERR}, {30'b0, resp});
        axi_write(12'h7c0, next_rand(), 0, resp);
        compare_value("bresp", {30'b0, `RESP_SLVERR}, {30'b0, resp});
        axi_read(12'h7c0, 4, data, resp);
        compare_value("rresp", {30'b0, `RESP_SLVERR}, {30'b0, resp});
        read_expect(`CSR_MHARTID, hart_id_value, "mhartid");

        // Synchronous trap from M-mode with MIE set and MPP left at U.
        word.raw = '0;
        word.mstatus.mie = 1'b1;
        word.mstatus.mpp = PRIV_U;
        axi_write(`CSR_MSTATUS, word.raw, 0, resp);
        val = next_rand();
        @(negedge clk);
        trap_valid   = 1'b1;
        retire_valid = 1'b1;
        retire_pc    = val[31:1];
        trap_cause   = 5'd2;
        @(negedge clk);
        trap_valid   = 1'b0;
        retire_valid = 1'b0;
        compare_value("priv", {30'b0, PRIV_M}, {30'b0, priv});
        read_expect(`CSR_MEPC, {val[31:1], 1'b0}, "mepc");
        word.raw = '0;
        word.mcause.code = 5'd2;
        read_expect(`CSR_MCAUSE, word.raw, "mcause");
        word.raw = '0;
        word.mstatus.mpie = 1'b1;
        word.mstatus.mpp  = PRIV_M;
        read_expect(`CSR_MSTATUS, word.raw, "mstatus");

        // MRET down to U-mode.
        word.raw = '0;
        word.mstatus.mpie = 1'b1;
        axi_write(`CSR_MSTATUS, word.raw, 0, resp);
        @(negedge clk);
        xret = 1'b1;
        @(negedge clk);
        xret = 1'b0;
        compare_value("priv", {30'b0, PRIV_U}, {30'b0, priv});
        axi_read(`CSR_MSTATUS, 0, data, resp);
        word.raw = data;
        compare_value("mstatus.mie", 32'd1, {31'b0, word.mstatus.mie});

        // Lines 16 and 20 raised, nothing enabled in mie yet.
        @(negedge clk);
        irq          = 16'h0011;
        retire_valid = 1'b1;
        retire_pc    = val[31:1];
        repeat (4) begin
            @(negedge clk);
            compare_value("redirect", 32'd0, {31'b0, redirect});
        end
        // Enabling both lines lets the interrupt in on the next retire.
        axi_write(`CSR_MIE, 32'h0011_0000, 0, resp);
        retire_valid = 1'b0;
        irq          = '0;
        compare_value("priv", {30'b0, PRIV_M}, {30'b0, priv});
        word.raw = '0;
        word.mcause.intr = 1'b1;
        word.mcause.code = 5'd16;
        read_expect(`CSR_MCAUSE, word.raw, "mcause");

        repeat (2) @(negedge clk);
        $display("errors: %0d value checks, %0d assertions", errors, UUT.props.fail_count);
        if (errors == 0 && UUT.props.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tests/mtrap_unit_properties.sv ====
// Bound assertions on redirect targets, interrupt priority, AXI responses and reset state.
`timescale 1ns/1ps
`include "mtrap_consts.svh"

module mtrap_unit_properties import mtrap_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             trap_valid,
    input logic             xret,
    input logic             take_irq,
    input logic             redirect,
    input logic [`XLEN-1:1] redirect_pc,
    input logic [`XLEN-1:2] mtvec_base,
    input logic [`XLEN-1:1] mepc,
    input trap_cause_t      cause,
    input logic [`XLEN-1:0] irq_ip,
    input logic [`XLEN-1:0] mie,
    input priv_t            priv,
    input logic             awready,
    input logic             wready,
    input logic             bvalid,
    input logic             bready,
    input logic [1:0]       bresp,
    input logic             arready,
    input logic             rvalid,
    input logic             rready,
    input logic [`XLEN-1:0] rdata,
    input logic [1:0]       rresp
);
    // Number of failed assertions.
    int fail_count = 0;

    // Lowest set bit of a pending vector.
    function automatic trap_cause_t lowest_set(input logic [`XLEN-1:0] v);
        for (int i = 0; i < `XLEN; i++) begin
            if (v[i]) begin
                return trap_cause_t'(i);
            end
        end
        return '0;
    endfunction

    // Trap or interrupt jumps to mtvec in the same cycle.
    trap_target: assert property (@(posedge clk) disable iff (rst)
        (trap_valid || take_irq) |-> redirect && redirect_pc == {mtvec_base, 1'b0})
    else begin
        $error("trap or interrupt without a redirect to mtvec");
        fail_count++;
    end

    // MRET with nothing else going on returns to mepc.
    ret_target: assert property (@(posedge clk) disable iff (rst)
        (xret && !trap_valid && !take_irq) |-> redirect && redirect_pc == mepc)
    else begin
        $error("return without a redirect to mepc");
        fail_count++;
    end

    // Lowest enabled pending line wins.
    irq_priority: assert property (@(posedge clk) disable iff (rst)
        take_irq |-> cause == lowest_set(irq_ip & mie))
    else begin
        $error("interrupt taken with a cause other than the lowest pending one");
        fail_count++;
    end

    // Nothing is enabled, so nothing is taken.
    irq_masked: assert property (@(posedge clk) disable iff (rst)
        (mie == '0) |-> !take_irq)
    else begin
        $error("interrupt taken while mie is zero");
        fail_count++;
    end

    // Write response held until the master takes it.
    b_hold: assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> bvalid && $stable(bresp))
    else begin
        $error("write response dropped or changed before bready");
        fail_count++;
    end

    // Read response held until the master takes it.
    r_hold: assert property (@(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        $error("read response dropped or changed before rready");
        fail_count++;
    end

    // No new write accepted while a response is pending.
    b_block: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> !awready && !wready)
    else begin
        $error("write accepted while a write response is pending");
        fail_count++;
    end

    // Reset state.
    reset_state: assert property (@(posedge clk)
        rst |=> priv == PRIV_M && !bvalid && !rvalid && !awready && !wready && !arready)
    else begin
        $error("unit not in its reset state after reset");
        fail_count++;
    end

endmodule

// ==== rtl/mtrap_unit.sv ====
// Machine trap unit top level with AXI4-Lite CSR access.
`timescale 1ns/1ps
`include "mtrap_consts.svh"

module mtrap_unit import mtrap_pkg::*; #(
    parameter logic [`XLEN-1:0] hart_id = '0
) (
    input  logic                           clk,
    input  logic                           rst,
    // Interrupt lines.
    input  logic [`IRQ_EXT_HI:`IRQ_EXT_LO] irq,
    input  logic                           timer_irq,
    // Retire and trap events.
    input  logic                           retire_valid,
    input  logic [`XLEN-1:1]               retire_pc,
    input  logic                           trap_valid,
    input  trap_cause_t                    trap_cause,
    input  logic                           xret,
    output logic                           redirect,
    output logic [`XLEN-1:1]               redirect_pc,
    output priv_t                          priv,
    // AXI4-Lite write channels.
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [11:0]                    awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [`XLEN-1:0]               wdata,
    output logic                           bvalid,
    input  logic                           bready,
    output logic [1:0]                     bresp,
    // AXI4-Lite read channels.
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [11:0]                    araddr,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [`XLEN-1:0]               rdata,
    output logic [1:0]                     rresp
);
    // Trap events to the CSR file.
    logic             take_trap;
    logic             take_irq;
    trap_cause_t      cause;
    logic [`XLEN-1:1] epc;
    priv_t            trap_priv;
    logic             do_ret;
    // CSR state back to control.
    logic [`XLEN-1:2] mtvec_base;
    logic [`XLEN-1:1] mepc;
    priv_t            mpp;
    logic [`XLEN-1:0] mie;
    logic             status_mie;
    // Interrupt arbiter results.
    logic [`XLEN-1:0] irq_ip;
    logic             irq_pending;
    trap_cause_t      irq_cause;

    csr_access_if csr_if ();

    csr_axil_slave u_axil (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .csr(csr_if)
    );

    csr_regs #(.hart_id(hart_id)) u_regs (
        .clk(clk), .rst(rst), .csr(csr_if),
        .take_trap(take_trap), .take_irq(take_irq), .cause(cause), .epc(epc),
        .trap_priv(trap_priv), .do_ret(do_ret), .irq_ip(irq_ip),
        .mtvec_base(mtvec_base), .mepc(mepc), .mpp(mpp), .mie(mie),
        .status_mie(status_mie)
    );

    irq_arbiter u_irq (
        .clk(clk), .irq(irq), .timer_irq(timer_irq), .mie(mie),
        .status_mie(status_mie), .irq_ip(irq_ip), .irq_pending(irq_pending),
        .irq_cause(irq_cause)
    );

    trap_ctrl u_ctrl (
        .clk(clk), .rst(rst), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .trap_valid(trap_valid), .trap_cause(trap_cause), .xret(xret),
        .irq_pending(irq_pending), .irq_cause(irq_cause),
        .mtvec_base(mtvec_base), .mepc(mepc), .mpp(mpp),
        .take_trap(take_trap), .take_irq(take_irq), .cause(cause), .epc(epc),
        .trap_priv(trap_priv), .do_ret(do_ret),
        .redirect(redirect), .redirect_pc(redirect_pc), .priv(priv)
    );

endmodule

// ==== rtl/trap_ctrl.sv ====
// Trap versus interrupt dispatch, MRET handling and the privilege register.
`timescale 1ns/1ps
`include "mtrap_consts.svh"

module trap_ctrl import mtrap_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    // Retiring instruction and its events.
    input  logic             retire_valid,
    input  logic [`XLEN-1:1] retire_pc,
    input  logic             trap_valid,
    input  trap_cause_t      trap_cause,
    input  logic             xret,
    // From the interrupt arbiter.
    input  logic             irq_pending,
    input  trap_cause_t      irq_cause,
    // From the CSR file.
    input  logic [`XLEN-1:2] mtvec_base,
    input  logic [`XLEN-1:1] mepc,
    input  priv_t            mpp,
    // To the CSR file.
    output logic             take_trap,
    output logic             take_irq,
    output trap_cause_t      cause,
    output logic [`XLEN-1:1] epc,
    output priv_t            trap_priv,
    output logic             do_ret,
    // To fetch.
    output logic             redirect,
    output logic [`XLEN-1:1] redirect_pc,
    output priv_t            priv
);
    // Interrupt first, then trap, then return.
    assign take_irq  = irq_pending && retire_valid;
    assign take_trap = trap_valid && !take_irq;
    assign do_ret    = xret && !trap_valid && !take_irq;

    assign cause     = take_irq ? irq_cause : trap_cause;
    assign epc       = retire_pc;
    assign trap_priv = priv;

    // Vectoring is direct mode only.
    assign redirect    = take_irq || take_trap || do_ret;
    assign redirect_pc = do_ret ? mepc : {mtvec_base, 1'b0};

    // Current privilege.
    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= PRIV_M;
        end else if (take_trap || take_irq) begin
            priv <= PRIV_M;
        end else if (do_ret) begin
            priv <= mpp;
        end
    end

endmodule

// ==== rtl/irq_arbiter.sv ====
// Interrupt latching, masking, lowest-number priority and delayed global enable.
`timescale 1ns/1ps
`include "mtrap_consts.svh"

module irq_arbiter import mtrap_pkg::*; (
    input  logic                            clk,
    input  logic [`IRQ_EXT_HI:`IRQ_EXT_LO]  irq,
    input  logic                            timer_irq,
    input  logic [`XLEN-1:0]                mie,
    input  logic                            status_mie,
    output logic [`XLEN-1:0]                irq_ip,
    output logic                            irq_pending,
    output trap_cause_t                     irq_cause
);
    // Line values before latching.
    logic [`XLEN-1:0]      ip_next;
    // Enabled pending lines.
    logic [`XLEN-1:0]      masked;
    // History of mstatus.MIE.
    logic [`MIE_DELAY-1:0] en_hist;

    always_comb begin
        ip_next = '0;
        ip_next[`IRQ_EXT_HI:`IRQ_EXT_LO] = irq;
        ip_next[`TIMER_IRQ_BIT] = timer_irq;
    end

    // Lines are sampled one cycle before use.
    always_ff @(posedge clk) begin
        irq_ip  <= ip_next;
        en_hist <= {en_hist[`MIE_DELAY-2:0], status_mie};
    end

    assign masked = irq_ip & mie;

    // Scan downwards so the lowest number is assigned last.
    always_comb begin
        irq_cause = '0;
        for (int i = `XLEN - 1; i >= 0; i--) begin
            if (masked[i]) begin
                irq_cause = trap_cause_t'(i);
            end
        end
    end

    // Global enable must have held for the whole delay.
    assign irq_pending = (|masked) && (&en_hist) && status_mie;

endmodule

// ==== rtl/csr_regs.sv ====
// M-mode CSR storage, read decoding, access checks and trap/return updates.
`timescale 1ns/1ps
`include "mtrap_consts.svh"

module csr_regs import mtrap_pkg::*; #(
    // Value of mhartid.
    parameter logic [`XLEN-1:0] hart_id = '0
) (
    input  logic              clk,
    input  logic              rst,
    csr_access_if.regs        csr,
    // Trap and return events.
    input  logic              take_trap,
    input  logic              take_irq,
    input  trap_cause_t       cause,
    input  logic [`XLEN-1:1]  epc,
    input  priv_t             trap_priv,
    input  logic              do_ret,
    // Latched interrupt lines.
    input  logic [`XLEN-1:0]  irq_ip,
    // State used by the trap controller and arbiter.
    output logic [`XLEN-1:2]  mtvec_base,
    output logic [`XLEN-1:1]  mepc,
    output priv_t             mpp,
    output logic [`XLEN-1:0]  mie,
    output logic              status_mie
);
    // mstatus fields.
    logic             status_mpie;
    logic             status_mprv;
    // mcause fields.
    logic             mcause_int;
    trap_cause_t      mcause_code;
    logic [`XLEN-1:0] mscratch;
    // Decoded views of write and read data.
    csr_word_u        wr;
    csr_word_u        rd;
    // Software write that lands this cycle; traps and returns win.
    logic             we;

    assign wr.raw = csr.wdata;
    assign we     = csr.access && csr.write && csr.exists && !csr.rdonly
                    && !take_trap && !take_irq && !do_ret;

    // Numbers 0xCxx to 0xFxx are read-only by encoding.
    assign csr.rdonly = (csr.addr[11:10] == 2'b11);

    // Read mux.
    always_comb begin
        rd.raw     = '0;
        csr.exists = 1'b1;
        case (csr.addr)
            `CSR_MSTATUS: begin
                rd.mstatus.mie  = status_mie;
                rd.mstatus.mpie = status_mpie;
                rd.mstatus.mpp  = mpp;
                rd.mstatus.mprv = status_mprv;
            end
            `CSR_MCAUSE: begin
                rd.mcause.intr = mcause_int;
                rd.mcause.code = mcause_code;
            end
            `CSR_MISA:      rd.raw = `MISA_VALUE;
            `CSR_MIE:       rd.raw = mie;
            `CSR_MIP:       rd.raw = irq_ip;
            `CSR_MTVEC:     rd.raw = {mtvec_base, 2'b00};
            `CSR_MSCRATCH:  rd.raw = mscratch;
            `CSR_MEPC:      rd.raw = {mepc, 1'b0};
            `CSR_MVENDORID: rd.raw = `MVENDORID_VALUE;
            `CSR_MARCHID:   rd.raw = `MARCHID_VALUE;
            `CSR_MIMPID:    rd.raw = `MIMPID_VALUE;
            `CSR_MHARTID:   rd.raw = hart_id;
            default:        csr.exists = 1'b0;
        endcase
        csr.rdata = rd.raw;
    end

    // Control CSRs.
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            status_mprv <= 1'b0;
            mpp         <= PRIV_M;
            mie         <= '0;
            mtvec_base  <= '0;
            mepc        <= '0;
            mcause_int  <= 1'b0;
            mcause_code <= '0;
        end else if (take_trap || take_irq) begin
            // Enter M-mode, stacking the enable and privilege.
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
            mpp         <= trap_priv;
            mepc        <= epc;
            mcause_int  <= take_irq;
            mcause_code <= cause;
        end else if (do_ret) begin
            status_mie <= status_mpie;
            // MPRV only survives a return to M.
            status_mprv <= status_mprv && (mpp == PRIV_M);
        end else if (we) begin
            case (csr.addr)
                `CSR_MSTATUS: begin
                    status_mie  <= wr.mstatus.mie;
                    status_mpie <= wr.mstatus.mpie;
                    status_mprv <= wr.mstatus.mprv;
                    // Only U and M exist.
                    mpp <= (wr.mstatus.mpp != 2'b00) ? PRIV_M : PRIV_U;
                end
                `CSR_MCAUSE: begin
                    mcause_int  <= wr.mcause.intr;
                    mcause_code <= wr.mcause.code;
                end
                `CSR_MIE:   mie        <= wr.raw;
                `CSR_MTVEC: mtvec_base <= wr.raw[`XLEN-1:2];
                `CSR_MEPC:  mepc       <= wr.raw[`XLEN-1:1];
                default: begin
                end
            endcase
        end
    end

    // Scratch register.
    always_ff @(posedge clk) begin
        if (we && csr.addr == `CSR_MSCRATCH) begin
            mscratch <= wr.raw;
        end
    end

endmodule

// ==== rtl/csr_axil_slave.sv ====
// AXI4-Lite slave turning bus transactions into single-cycle CSR accesses.
`timescale 1ns/1ps
`include "mtrap_consts.svh"

module csr_axil_slave (
    input  logic             clk,
    input  logic             rst,
    // Write address and data.
    input  logic             awvalid,
    output logic             awready,
    input  logic [11:0]      awaddr,
    input  logic             wvalid,
    output logic             wready,
    input  logic [`XLEN-1:0] wdata,
    // Write response.
    output logic             bvalid,
    input  logic             bready,
    output logic [1:0]       bresp,
    // Read address.
    input  logic             arvalid,
    output logic             arready,
    input  logic [11:0]      araddr,
    // Read data.
    output logic             rvalid,
    input  logic             rready,
    output logic [`XLEN-1:0] rdata,
    output logic [1:0]       rresp,
    csr_access_if.bus        csr
);
    // Write accepted at the next edge.
    logic wr_start;
    // Read accepted at the next edge, writes take precedence.
    logic rd_start;
    // Handshake cycles, one per transaction.
    logic wr_go;
    logic rd_go;

    assign wr_start = awvalid && wvalid && !bvalid && !awready;
    assign rd_start = arvalid && !rvalid && !arready && !wr_start && !awready;
    assign wr_go    = awready && awvalid && wvalid;
    assign rd_go    = arready && arvalid;

    // Drive the CSR port from whichever channel is in its handshake.
    assign csr.access = wr_go || rd_go;
    assign csr.write  = wr_go;
    assign csr.addr   = wr_go ? awaddr : araddr;
    assign csr.wdata  = wdata;

    // Ready pulses and pending responses.
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= wr_start;
            wready  <= wr_start;
            arready <= rd_start;
            // Response held until the master takes it.
            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_go) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload, captured at the handshake.
    always_ff @(posedge clk) begin
        if (wr_go) begin
            bresp <= (!csr.exists || csr.rdonly) ? `RESP_SLVERR : `RESP_OKAY;
        end
        if (rd_go) begin
            rresp <= csr.exists ? `RESP_OKAY : `RESP_SLVERR;
            rdata <= csr.exists ? csr.rdata : '0;
        end
    end

endmodule

// ==== rtl/csr_access_if.sv ====
// CSR access interface between the bus front end and the CSR file.
`timescale 1ns/1ps
`include "mtrap_consts.svh"

interface csr_access_if;
    // Single-cycle access strobe.
    logic             access;
    // High for a write, low for a read.
    logic             write;
    // CSR number.
    logic [11:0]      addr;
    logic [`XLEN-1:0] wdata;
    // Read data and status, combinational from addr.
    logic [`XLEN-1:0] rdata;
    logic             exists;
    logic             rdonly;

    // Bus front end.
    modport bus (output access, write, addr, wdata, input rdata, exists, rdonly);

    // CSR file.
    modport regs (input access, write, addr, wdata, output rdata, exists, rdonly);

endinterface

// ==== rtl/mtrap_pkg.sv ====
// Privilege, trap cause and CSR data word types for the machine trap unit.
`include "mtrap_consts.svh"

package mtrap_pkg;

    // Privilege levels; only U and M are implemented.
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_t;

    // Trap or interrupt number.
    typedef logic [4:0] trap_cause_t;

    // mstatus layout, M-mode fields only.
    typedef struct packed {
        logic [13:0] rsvd_31_18;
        logic        mprv;
        logic [3:0]  rsvd_16_13;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    // mcause layout.
    typedef struct packed {
        logic        intr;
        logic [25:0] rsvd;
        trap_cause_t code;
    } mcause_t;

    // One CSR data word in its raw and decoded views.
    typedef union packed {
        logic [`XLEN-1:0] raw;
        mstatus_t         mstatus;
        mcause_t          mcause;
    } csr_word_u;

endpackage

// ==== rtl/mtrap_consts.svh ====
// CSR numbers, ID values, interrupt bit positions, sizes and AXI response codes.
`ifndef MTRAP_CONSTS_SVH
`define MTRAP_CONSTS_SVH

// Data word width.
`define XLEN            32

// Machine-mode CSR numbers.
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MIP         12'h344
`define CSR_MVENDORID   12'hf11
`define CSR_MARCHID     12'hf12
`define CSR_MIMPID      12'hf13
`define CSR_MHARTID     12'hf14

// Fixed ID and ISA values.
// RV32I with U-mode: MXL = 1, I and U bits set.
`define MISA_VALUE      32'h4010_0100
`define MVENDORID_VALUE 32'h0000_0000
`define MARCHID_VALUE   32'd37
// Version 2.0.0 in the major/minor/patch fields.
`define MIMPID_VALUE    32'h0000_0200

// Interrupt line positions in mip and mie.
`define TIMER_IRQ_BIT   5'd7
`define IRQ_EXT_LO      16
`define IRQ_EXT_HI      31

// Cycles a set mstatus.MIE waits before enabling interrupts.
`define MIE_DELAY       2

// AXI4-Lite response codes.
`define RESP_OKAY       2'b00
`define RESP_SLVERR     2'b10

`endif
